// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_MemoryBridge
FILELIST ?= MemoryBridge.f
BUILD_DIR ?= obj_dir
LOG ?= simulate.log
VFLAGS ?= --binary --timing

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== MemoryBridge.f ====
rtl/MemBridgePkg.sv
rtl/MemReqIf.sv
rtl/ResetController.sv
rtl/BridgeSequencer.sv
rtl/RequestRegister.sv
rtl/ReturnRegister.sv
rtl/MemoryBridge.sv
verification/PinMemoryModel.sv
verification/tb_MemoryBridge.sv

// ==== rtl/BridgeSequencer.sv ====
// ##############################
// Bridge request sequencer
// ##############################

`timescale 1ns/100ps
`default_nettype none

module BridgeSequencer (
input
    logic coreClk,
    logic arstN,
    logic rst,
    MemReqIf.user req,
    logic coreMemAccessRE,
    logic coreMemAccessWE,
    logic pinMemAccessBusy,     // pin side cannot take a request
output
    logic capture,              // load the request register
    logic clear,                // drop the held flags
    logic issue,                // pin strobe enable
    logic coreMemAccessBusy
);

    MemBridgePkg::BridgeState state;
    MemBridgePkg::BridgeState nextState;
    logic coreStrobe;

    assign coreStrobe = coreMemAccessRE | coreMemAccessWE;

    always_ff @(posedge coreClk or negedge arstN) begin
        if (!arstN) begin
            state <= MemBridgePkg::Idle;
        end else if (rst) begin
            state <= MemBridgePkg::Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            MemBridgePkg::Idle: begin
                if (coreStrobe) begin
                    nextState = MemBridgePkg::Hold;
                end
            end
            MemBridgePkg::Hold: begin
                // wait here as long as the pins push back
                if (!pinMemAccessBusy) begin
                    nextState = MemBridgePkg::Issue;
                end
            end
            MemBridgePkg::Issue: begin
                nextState = MemBridgePkg::Idle;    // single cycle strobe
            end
            default: begin
                nextState = MemBridgePkg::Idle;
            end
        endcase
    end

    // accept only when idle and out of reset
    assign capture = (state == MemBridgePkg::Idle) && coreStrobe && !rst;

    // held flags say whether there is anything to send
    assign issue = (state == MemBridgePkg::Issue) && (req.re | req.we);
    assign clear = (state == MemBridgePkg::Issue);

    // busy from the cycle after acceptance through Issue
    assign coreMemAccessBusy = rst || (state != MemBridgePkg::Idle);

endmodule : BridgeSequencer

`default_nettype wire

// ==== rtl/MemBridgePkg.sv ====
// ##############################
// Memory bridge types
// ##############################

`default_nettype none

package MemBridgePkg;

    // bus word widths
    localparam int ADDR_WIDTH = 32;
    localparam int ENTRY_WIDTH = 64;
    localparam int SERIAL_WIDTH = 4;

    typedef logic [ADDR_WIDTH-1:0] AddrPath;              // byte address
    typedef logic [ENTRY_WIDTH-1:0] MemoryEntryDataPath;  // one entry per access
    typedef logic [SERIAL_WIDTH-1:0] MemAccessSerial;     // read id
    typedef logic [SERIAL_WIDTH-1:0] MemWriteSerial;      // write id

    // one finished write
    typedef struct packed {
        logic valid;
        MemWriteSerial serial;
    } MemAccessResponse;

    // core reset is stretched by this many clocks after arstN rises
    localparam int RESET_CYCLES = 4;
    localparam int RESET_COUNT_WIDTH = $clog2(RESET_CYCLES + 1);

    typedef enum logic [1:0] {
        Idle  = 2'd0,   // waiting for a core strobe
        Hold  = 2'd1,   // request held, pin side busy
        Issue = 2'd2    // pin strobe this cycle
    } BridgeState;

endpackage : MemBridgePkg

`default_nettype wire

// ==== rtl/MemReqIf.sv ====
// ##############################
// Held memory request
// ##############################

`timescale 1ns/100ps
`default_nettype none

interface MemReqIf;

    MemBridgePkg::AddrPath addr;                // held address
    MemBridgePkg::MemoryEntryDataPath writeData; // held write data
    logic re;   // held read flag
    logic we;   // held write flag

    // the register that owns the request
    modport holder (
        output addr, writeData, re, we
    );

    // sequencer and top level
    modport user (
        input addr, writeData, re, we
    );

endinterface : MemReqIf

`default_nettype wire

// ==== rtl/MemoryBridge.sv ====
// ##############################
// Memory bridge top
// ##############################

`timescale 1ns/100ps
`default_nettype none

module MemoryBridge (
input
    logic coreClk,
    logic arstN,    // asynchronous, active low
output
    logic posResetOut,  // core reset, active high

    // pin side
output
    MemBridgePkg::AddrPath pinMemAccessAddr,
    MemBridgePkg::MemoryEntryDataPath pinMemAccessWriteData,
    logic pinMemAccessRE,
    logic pinMemAccessWE,
input
    logic pinMemAccessBusy,                             // pins cannot take a request
    MemBridgePkg::MemAccessSerial pinNextMemReadSerial, // id of the next read
    MemBridgePkg::MemWriteSerial pinNextMemWriteSerial, // id of the next write
    logic pinMemReadDataReady,
    MemBridgePkg::MemoryEntryDataPath pinMemReadData,
    MemBridgePkg::MemAccessSerial pinMemReadSerial,
    MemBridgePkg::MemAccessResponse pinMemAccessResponse,   // write done

    // core side
input
    MemBridgePkg::AddrPath coreMemAccessAddr,
    MemBridgePkg::MemoryEntryDataPath coreMemAccessWriteData,
    logic coreMemAccessRE,
    logic coreMemAccessWE,
output
    logic coreMemAccessBusy,
    MemBridgePkg::MemAccessSerial coreNextMemReadSerial,
    MemBridgePkg::MemWriteSerial coreNextMemWriteSerial,
    logic coreMemReadDataReady,
    MemBridgePkg::MemoryEntryDataPath coreMemReadData,
    MemBridgePkg::MemAccessSerial coreMemReadSerial,
    MemBridgePkg::MemAccessResponse coreMemAccessResponse
);

    logic rst;
    logic capture;
    logic clear;
    logic issue;

    MemReqIf reqIf ();

    ResetController rstController (
        .coreClk(coreClk),
        .arstN(arstN),
        .rst(rst)
    );

    BridgeSequencer sequencer (
        .coreClk(coreClk),
        .arstN(arstN),
        .rst(rst),
        .req(reqIf.user),
        .coreMemAccessRE(coreMemAccessRE),
        .coreMemAccessWE(coreMemAccessWE),
        .pinMemAccessBusy(pinMemAccessBusy),
        .capture(capture),
        .clear(clear),
        .issue(issue),
        .coreMemAccessBusy(coreMemAccessBusy)
    );

    RequestRegister reqReg (
        .coreClk(coreClk),
        .arstN(arstN),
        .rst(rst),
        .capture(capture),
        .clear(clear),
        .coreMemAccessAddr(coreMemAccessAddr),
        .coreMemAccessWriteData(coreMemAccessWriteData),
        .coreMemAccessRE(coreMemAccessRE),
        .coreMemAccessWE(coreMemAccessWE),
        .req(reqIf.holder)
    );

    ReturnRegister retReg (
        .coreClk(coreClk),
        .arstN(arstN),
        .rst(rst),
        .pinMemReadDataReady(pinMemReadDataReady),
        .pinMemReadData(pinMemReadData),
        .pinMemReadSerial(pinMemReadSerial),
        .pinMemAccessResponse(pinMemAccessResponse),
        .coreMemReadDataReady(coreMemReadDataReady),
        .coreMemReadData(coreMemReadData),
        .coreMemReadSerial(coreMemReadSerial),
        .coreMemAccessResponse(coreMemAccessResponse)
    );

    assign posResetOut = rst;

    // held request goes out on the Issue cycle only
    assign pinMemAccessAddr = reqIf.addr;
    assign pinMemAccessWriteData = reqIf.writeData;
    assign pinMemAccessRE = issue & reqIf.re;
    assign pinMemAccessWE = issue & reqIf.we;

    // serial ids are owned by the pin side
    assign coreNextMemReadSerial = pinNextMemReadSerial;
    assign coreNextMemWriteSerial = pinNextMemWriteSerial;

endmodule : MemoryBridge

`default_nettype wire

// ==== rtl/RequestRegister.sv ====
// ##############################
// Core request register
// ##############################

`timescale 1ns/100ps
`default_nettype none

module RequestRegister (
input
    logic coreClk,
    logic arstN,
    logic rst,
    logic capture,
    logic clear,
    MemBridgePkg::AddrPath coreMemAccessAddr,
    MemBridgePkg::MemoryEntryDataPath coreMemAccessWriteData,
    logic coreMemAccessRE,
    logic coreMemAccessWE,
output
    MemReqIf.holder req
);

    // address and data only matter while a flag is set
    always_ff @(posedge coreClk) begin
        if (capture) begin
            req.addr <= coreMemAccessAddr;
            req.writeData <= coreMemAccessWriteData;
        end
    end

    always_ff @(posedge coreClk or negedge arstN) begin
        if (!arstN) begin
            req.re <= 1'b0;
            req.we <= 1'b0;
        end else if (rst || clear) begin
            req.re <= 1'b0;     // request has gone out
            req.we <= 1'b0;
        end else if (capture) begin
            req.re <= coreMemAccessRE;
            req.we <= coreMemAccessWE & ~coreMemAccessRE;  // read wins
        end
    end

endmodule : RequestRegister

`default_nettype wire

// ==== rtl/ResetController.sv ====
// ##############################
// Core reset stretcher
// ##############################

`timescale 1ns/100ps
`default_nettype none

module ResetController (
input
    logic coreClk,
    logic arstN,    // asynchronous, active low
output
    logic rst       // synchronous core reset, active high
);

    logic [MemBridgePkg::RESET_COUNT_WIDTH-1:0] count;

    // reload while arstN is low, then count the release edges
    always_ff @(posedge coreClk or negedge arstN) begin
        if (!arstN) begin
            count <= MemBridgePkg::RESET_COUNT_WIDTH'(MemBridgePkg::RESET_CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;  // stops at zero
        end
    end

    // high until the counter runs out
    assign rst = (count != '0);

endmodule : ResetController

`default_nettype wire

// ==== rtl/ReturnRegister.sv ====
// ##############################
// Return path register
// ##############################

`timescale 1ns/100ps
`default_nettype none

module ReturnRegister (
input
    logic coreClk,
    logic arstN,
    logic rst,
    logic pinMemReadDataReady,
    MemBridgePkg::MemoryEntryDataPath pinMemReadData,
    MemBridgePkg::MemAccessSerial pinMemReadSerial,
    MemBridgePkg::MemAccessResponse pinMemAccessResponse,
output
    logic coreMemReadDataReady,
    MemBridgePkg::MemoryEntryDataPath coreMemReadData,
    MemBridgePkg::MemAccessSerial coreMemReadSerial,
    MemBridgePkg::MemAccessResponse coreMemAccessResponse
);

    logic respValid;
    MemBridgePkg::MemWriteSerial respSerial;

    always_ff @(posedge coreClk or negedge arstN) begin
        if (!arstN) begin
            coreMemReadDataReady <= 1'b0;
            respValid <= 1'b0;
        end else if (rst) begin
            coreMemReadDataReady <= 1'b0;
            respValid <= 1'b0;
        end else begin
            coreMemReadDataReady <= pinMemReadDataReady;
            respValid <= pinMemAccessResponse.valid;
        end
    end

    // last valid read stays visible between returns
    always_ff @(posedge coreClk) begin
        if (pinMemReadDataReady) begin
            coreMemReadData <= pinMemReadData;
            coreMemReadSerial <= pinMemReadSerial;
        end
        respSerial <= pinMemAccessResponse.serial;
    end

    always_comb begin
        coreMemAccessResponse.valid = respValid;
        coreMemAccessResponse.serial = respSerial;
    end

endmodule : ReturnRegister

`default_nettype wire

// ==== verification/PinMemoryModel.sv ====
// ##############################
// Pin side memory model
// ##############################

`timescale 1ns/100ps
`default_nettype none

module PinMemoryModel (
input
    logic coreClk,
    logic arstN,
    MemBridgePkg::AddrPath pinMemAccessAddr,
    MemBridgePkg::MemoryEntryDataPath pinMemAccessWriteData,
    logic pinMemAccessRE,
    logic pinMemAccessWE,
    logic busyLoad,         // start a busy window
    logic [3:0] busyCycles, // length of that window
output
    logic pinMemAccessBusy,
    MemBridgePkg::MemAccessSerial pinNextMemReadSerial,
    MemBridgePkg::MemWriteSerial pinNextMemWriteSerial,
    logic pinMemReadDataReady,
    MemBridgePkg::MemoryEntryDataPath pinMemReadData,
    MemBridgePkg::MemAccessSerial pinMemReadSerial,
    MemBridgePkg::MemAccessResponse pinMemAccessResponse
);

    MemBridgePkg::MemoryEntryDataPath mem [16];
    MemBridgePkg::MemoryEntryDataPath readDataPending;
    MemBridgePkg::MemAccessSerial readSerialPending;
    MemBridgePkg::MemAccessResponse respPending;
    logic [3:0] busyCount;
    logic [3:0] index;
    logic readPending;

    assign index = pinMemAccessAddr[6:3];   // one entry per 8 bytes
    assign pinMemAccessBusy = (busyCount != 4'd0);

    always_ff @(posedge coreClk or negedge arstN) begin
        if (!arstN) begin
            busyCount <= 4'd0;
            pinNextMemReadSerial <= '0;
            pinNextMemWriteSerial <= '0;
            readPending <= 1'b0;
            respPending <= '0;
            pinMemReadDataReady <= 1'b0;
            pinMemAccessResponse <= '0;
        end else begin
            if (busyLoad) begin
                busyCount <= busyCycles;
            end else if (busyCount != 4'd0) begin
                busyCount <= busyCount - 4'd1;
            end
            if (pinMemAccessRE) pinNextMemReadSerial <= pinNextMemReadSerial + 4'd1;
            if (pinMemAccessWE) pinNextMemWriteSerial <= pinNextMemWriteSerial + 4'd1;
            readPending <= pinMemAccessRE;
            respPending.valid <= pinMemAccessWE;
            respPending.serial <= pinNextMemWriteSerial;   // id of this write
            pinMemReadDataReady <= readPending;             // second cycle after strobe
            pinMemAccessResponse <= respPending;
        end
    end

    always_ff @(posedge coreClk) begin
        if (pinMemAccessWE) mem[index] <= pinMemAccessWriteData;
        if (pinMemAccessRE) begin
            readDataPending <= mem[index];
            readSerialPending <= pinNextMemReadSerial;
        end
        if (readPending) begin
            pinMemReadData <= readDataPending;
            pinMemReadSerial <= readSerialPending;
        end
    end

endmodule : PinMemoryModel

`default_nettype wire

// ==== verification/tb_MemoryBridge.sv ====
// ##############################
// Memory bridge testbench
// ##############################

`timescale 1ns/100ps
`default_nettype none

module tb_MemoryBridge;

    localparam int NUM_ROWS = 12;

    typedef struct packed {
        logic isWrite;
        logic isRandom;     // data comes from $urandom
        logic [3:0] busy;   // pin busy cycles
        MemBridgePkg::AddrPath addr;
        MemBridgePkg::MemoryEntryDataPath data;
    } StimRow;

    logic coreClk, arstN, posResetOut, busyLoad;
    logic [3:0] busyCycles;
    logic coreMemAccessRE, coreMemAccessWE, coreMemAccessBusy, coreMemReadDataReady;
    logic pinMemAccessRE, pinMemAccessWE, pinMemAccessBusy, pinMemReadDataReady;
    MemBridgePkg::AddrPath coreMemAccessAddr, pinMemAccessAddr;
    MemBridgePkg::MemoryEntryDataPath coreMemAccessWriteData, pinMemAccessWriteData;
    MemBridgePkg::MemoryEntryDataPath coreMemReadData, pinMemReadData;
    MemBridgePkg::MemAccessSerial coreNextMemReadSerial, pinNextMemReadSerial;
    MemBridgePkg::MemAccessSerial coreMemReadSerial, pinMemReadSerial;
    MemBridgePkg::MemWriteSerial coreNextMemWriteSerial, pinNextMemWriteSerial;
    MemBridgePkg::MemAccessResponse coreMemAccessResponse, pinMemAccessResponse;
    MemBridgePkg::MemoryEntryDataPath shadow [MemBridgePkg::AddrPath];   // last write per address
    MemBridgePkg::MemAccessSerial readSerialCount = '0;     // id of the next read
    MemBridgePkg::MemWriteSerial writeSerialCount = '0;     // id of the next write
    int strobeCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    // write, random data, busy cycles, address, write data
    StimRow stimRows [NUM_ROWS] = '{
        '{1'b1, 1'b0, 4'd0, 32'h0000_0000, 64'h0123_4567_89AB_CDEF},
        '{1'b0, 1'b0, 4'd0, 32'h0000_0000, 64'h0},
        '{1'b1, 1'b0, 4'd3, 32'h0000_0008, 64'hFEDC_BA98_7654_3210},
        '{1'b0, 1'b0, 4'd0, 32'h0000_0008, 64'h0},
        '{1'b1, 1'b1, 4'd5, 32'h0000_0010, 64'h0},
        '{1'b0, 1'b0, 4'd2, 32'h0000_0010, 64'h0},
        '{1'b1, 1'b1, 4'd0, 32'h0000_0000, 64'h0},
        '{1'b0, 1'b0, 4'd1, 32'h0000_0000, 64'h0},
        '{1'b1, 1'b1, 4'd0, 32'h0000_0048, 64'h0},
        '{1'b1, 1'b1, 4'd0, 32'h0000_0018, 64'h0},
        '{1'b0, 1'b0, 4'd4, 32'h0000_0048, 64'h0},
        '{1'b0, 1'b0, 4'd0, 32'h0000_0018, 64'h0}
    };

    MemoryBridge UUT (.*);
    PinMemoryModel pinMemory (.*);

    task automatic reportMismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic checkLevel(input string what, input logic actual, input logic expected);
        if (actual !== expected) reportMismatch($sformatf("%s is %b", what, actual));
    endtask

    task automatic checkPinRequest(input MemBridgePkg::AddrPath addr,
                                   input MemBridgePkg::MemoryEntryDataPath data,
                                   input MemBridgePkg::AddrPath expAddr,
                                   input MemBridgePkg::MemoryEntryDataPath expData);
        if (addr !== expAddr || data !== expData) begin
            reportMismatch($sformatf("pin request %h/%h, expected %h/%h",
                                     addr, data, expAddr, expData));
        end
    endtask

    task automatic checkNextSerials(input MemBridgePkg::MemAccessSerial readSerial,
                                    input MemBridgePkg::MemWriteSerial writeSerial,
                                    input MemBridgePkg::MemAccessSerial expReadSerial,
                                    input MemBridgePkg::MemWriteSerial expWriteSerial);
        if (readSerial !== expReadSerial || writeSerial !== expWriteSerial) begin
            reportMismatch($sformatf("next ids %0d/%0d, expected %0d/%0d",
                                     readSerial, writeSerial, expReadSerial, expWriteSerial));
        end
    endtask

    task automatic checkReadReturn(input MemBridgePkg::MemoryEntryDataPath data,
                                   input MemBridgePkg::MemAccessSerial serial,
                                   input MemBridgePkg::MemoryEntryDataPath expData,
                                   input MemBridgePkg::MemAccessSerial expSerial);
        if (data !== expData || serial !== expSerial) begin
            reportMismatch($sformatf("read return %h id %0d, expected %h id %0d",
                                     data, serial, expData, expSerial));
        end
    endtask

    task automatic checkResponse(input MemBridgePkg::MemAccessResponse actual,
                                 input MemBridgePkg::MemAccessResponse expected);
        if (actual !== expected) begin
            reportMismatch($sformatf("write response %b, expected %b", actual, expected));
        end
    endtask

    task automatic runRow(input StimRow row);
        MemBridgePkg::MemAccessSerial expReadSerial;
        MemBridgePkg::MemAccessResponse expResp;
        expReadSerial = readSerialCount;    // the model numbers requests in order
        expResp.valid = 1'b1;
        expResp.serial = writeSerialCount;
        @(negedge coreClk);
        while (coreMemAccessBusy) @(negedge coreClk);
        checkNextSerials(coreNextMemReadSerial, coreNextMemWriteSerial,
                         expReadSerial, expResp.serial);
        @(posedge coreClk);
        coreMemAccessAddr <= row.addr;
        coreMemAccessWriteData <= row.data;
        coreMemAccessRE <= !row.isWrite;
        coreMemAccessWE <= row.isWrite;
        busyCycles <= row.busy;
        busyLoad <= 1'b1;
        @(posedge coreClk);
        coreMemAccessRE <= 1'b0;
        coreMemAccessWE <= 1'b0;
        busyLoad <= 1'b0;
        // held while the pins push back, strobe follows the first free cycle
        for (int waited = 2; waited < int'(row.busy) + 3; waited++) begin
            @(negedge coreClk);
            checkLevel("core busy while held", coreMemAccessBusy, 1'b1);
            checkLevel("pin strobe while held", pinMemAccessRE | pinMemAccessWE, 1'b0);
        end
        @(negedge coreClk);
        checkLevel("core busy at issue", coreMemAccessBusy, 1'b1);
        checkLevel("pinMemAccessRE at issue", pinMemAccessRE, !row.isWrite);
        checkLevel("pinMemAccessWE at issue", pinMemAccessWE, row.isWrite);
        checkPinRequest(pinMemAccessAddr, pinMemAccessWriteData, row.addr, row.data);
        @(negedge coreClk);
        checkLevel("core busy after issue", coreMemAccessBusy, 1'b0);
        if (row.isWrite) begin
            shadow[row.addr] = row.data;
            writeSerialCount = writeSerialCount + 1'b1;
            while (!pinMemAccessResponse.valid) @(negedge coreClk);
            @(negedge coreClk);     // one return stage
            checkResponse(coreMemAccessResponse, expResp);
        end else begin
            readSerialCount = readSerialCount + 1'b1;
            while (!pinMemReadDataReady) @(negedge coreClk);
            @(negedge coreClk);
            checkLevel("coreMemReadDataReady", coreMemReadDataReady, 1'b1);
            checkReadReturn(coreMemReadData, coreMemReadSerial, shadow[row.addr], expReadSerial);
        end
    endtask

    initial begin
        coreClk = 1'b0;
        forever #5 coreClk = ~coreClk;
    end

    always @(posedge coreClk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TEST FAIL");
            $fatal(1, "run timed out");
        end
    end

    always @(negedge coreClk) begin
        if (pinMemAccessRE | pinMemAccessWE) strobeCount <= strobeCount + 1;
    end

    initial begin
        int maxBusy;
        maxBusy = 0;
        arstN = 1'b0;
        coreMemAccessAddr = '0;
        coreMemAccessWriteData = '0;
        coreMemAccessRE = 1'b0;
        coreMemAccessWE = 1'b0;
        busyLoad = 1'b0;
        busyCycles = 4'd0;
        void'($urandom(15232));
        foreach (stimRows[i]) begin
            if (stimRows[i].isRandom) stimRows[i].data = {$urandom(), $urandom()};
            if (int'(stimRows[i].busy) > maxBusy) maxBusy = int'(stimRows[i].busy);
        end
        cycleLimit = NUM_ROWS * (maxBusy + 10) + 20;
        repeat (3) @(posedge coreClk);
        arstN <= 1'b1;
        coreMemAccessWE <= 1'b1;    // a strobe in the stretched reset is never accepted
        // core reset holds for RESET_CYCLES edges after release
        repeat (MemBridgePkg::RESET_CYCLES) begin
            @(negedge coreClk);
            checkLevel("posResetOut in reset", posResetOut, 1'b1);
            checkLevel("core busy in reset", coreMemAccessBusy, 1'b1);
            checkLevel("pin strobe in reset", pinMemAccessRE | pinMemAccessWE, 1'b0);
            checkLevel("read ready in reset", coreMemReadDataReady, 1'b0);
        end
        @(posedge coreClk);
        coreMemAccessWE <= 1'b0;
        @(negedge coreClk);
        checkLevel("posResetOut after reset", posResetOut, 1'b0);
        foreach (stimRows[i]) runRow(stimRows[i]);
        if (strobeCount != NUM_ROWS) begin
            reportMismatch($sformatf("%0d pin strobes for %0d rows", strobeCount, NUM_ROWS));
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule : tb_MemoryBridge

`default_nettype wire
